//--- cfg_consts.svh
// Codes assume a 64-bit stream with 3DW Cfg headers; the timeout count is in com_cclk cycles
`ifndef CFG_CONSTS_SVH
`define CFG_CONSTS_SVH

// TLP format and type codes
`define CFG_FMT_RD         3'b000      // 3DW without data
`define CFG_FMT_WR         3'b010      // 3DW with data
`define CFG_TYPE_HI        4'b0010     // Type[4:1], Type[0] from cfg_type
`define MSG_FMT            3'b011      // 4DW with data
`define MSG_TYPE           5'b10100    // Terminate at receiver
`define MSG_CODE_SPL       8'h50       // Set_Slot_Power_Limit
`define TLP_LEN_ONE        10'd1       // Single DW payload

// Stream byte strobes
`define STRB_FULL          8'hFF
`define STRB_LOW           8'h0F       // Lower DW only

// Rx user sideband
`define RX_TUSER_W         22
`define RX_SOF_BIT         14          // Start of frame flag

// About 50 us at 125 MHz
`define CPL_TIMEOUT_CYCLES 32'd6250

`endif

//--- cfg_pkg.sv
// Types fixed for the 64-bit datapath and 3-bit rolling tags
`default_nettype none

package cfg_pkg;

  typedef logic [2:0]  tag_t;          // Rolling request tag
  typedef logic [2:0]  cpl_status_t;   // Completion status field
  typedef logic [63:0] beat_t;         // One stream data word
  typedef logic [7:0]  strb_t;         // Byte strobe per beat

  typedef enum logic [1:0] {
    resp_okay   = 2'b00,
    resp_slverr = 2'b10                // Failed or timed-out request
  } axi_resp_t;

endpackage

`default_nettype wire

//--- axil_req_ctl.sv
// One request outstanding at a time; a write starts only when awvalid and wvalid are both high
`default_nettype none

module axil_req_ctl (
  input  logic                 com_cclk,
  input  logic                 com_sysrst,
  input  logic                 s_axi_ctl_awvalid,
  output logic                 s_axi_ctl_awready,
  input  logic                 s_axi_ctl_wvalid,
  output logic                 s_axi_ctl_wready,
  output logic                 s_axi_ctl_bvalid,
  output cfg_pkg::axi_resp_t   s_axi_ctl_bresp,
  input  logic                 s_axi_ctl_bready,
  input  logic                 s_axi_ctl_arvalid,
  output logic                 s_axi_ctl_arready,
  output logic                 s_axi_ctl_rvalid,
  output logic [31:0]          s_axi_ctl_rdata,
  output cfg_pkg::axi_resp_t   s_axi_ctl_rresp,
  input  logic                 s_axi_ctl_rready,
  input  logic                 cpl_match,        // Status and payload valid with it
  input  cfg_pkg::cpl_status_t cpl_status_q,
  input  logic [31:0]          cpl_payload,
  input  logic                 timeout_hit,
  input  logic                 msg_done,
  output logic                 wr_accept,
  output logic                 rd_accept,
  output logic                 resp_done,
  output cfg_pkg::cpl_status_t cpl_status,
  output logic                 msg_sent
);

  import cfg_pkg::*;

  logic      request_in_progress;   // Ready pulse until b/r handshake
  logic      rd_req;                // Open request is a read
  logic      resp_issued;           // b/r loaded so later results drop
  logic      result_take;           // Result for the open request
  axi_resp_t cpl_resp;              // Response from completion status

  assign wr_accept   = s_axi_ctl_awready && s_axi_ctl_awvalid;
  assign rd_accept   = s_axi_ctl_arready && s_axi_ctl_arvalid;
  assign resp_done   = (s_axi_ctl_bvalid && s_axi_ctl_bready) ||
                       (s_axi_ctl_rvalid && s_axi_ctl_rready);
  assign result_take = request_in_progress && !resp_issued &&
                       (cpl_match || timeout_hit || msg_done);
  assign cpl_resp    = (cpl_status_q == '0) ? resp_okay : resp_slverr;

  always_ff @(posedge com_cclk) begin
    if (com_sysrst) begin
      s_axi_ctl_awready   <= 1'b0;
      s_axi_ctl_wready    <= 1'b0;
      s_axi_ctl_arready   <= 1'b0;
      s_axi_ctl_bvalid    <= 1'b0;
      s_axi_ctl_bresp     <= resp_okay;
      s_axi_ctl_rvalid    <= 1'b0;
      s_axi_ctl_rresp     <= resp_okay;
      request_in_progress <= 1'b0;
      rd_req              <= 1'b0;
      resp_issued         <= 1'b0;
      cpl_status          <= '0;
      msg_sent            <= 1'b0;
    end else begin
      s_axi_ctl_awready <= 1'b0;                // Ready pulses last one cycle
      s_axi_ctl_wready  <= 1'b0;
      s_axi_ctl_arready <= 1'b0;
      if (!request_in_progress) begin
        if (s_axi_ctl_awvalid && s_axi_ctl_wvalid) begin   // Write wins over read
          s_axi_ctl_awready   <= 1'b1;
          s_axi_ctl_wready    <= 1'b1;
          request_in_progress <= 1'b1;
          rd_req              <= 1'b0;
        end else if (s_axi_ctl_arvalid) begin
          s_axi_ctl_arready   <= 1'b1;
          request_in_progress <= 1'b1;
          rd_req              <= 1'b1;
        end
      end
      if (result_take) begin
        resp_issued <= 1'b1;
        if (msg_done) begin                     // Message needs no completion
          s_axi_ctl_bvalid <= 1'b1;
          s_axi_ctl_bresp  <= resp_okay;
          msg_sent         <= 1'b1;
        end else if (timeout_hit) begin
          if (rd_req) begin
            s_axi_ctl_rvalid <= 1'b1;
            s_axi_ctl_rresp  <= resp_slverr;
          end else begin
            s_axi_ctl_bvalid <= 1'b1;
            s_axi_ctl_bresp  <= resp_slverr;
          end
        end else begin
          cpl_status <= cpl_status_q;           // Visible with the response
          if (rd_req) begin
            s_axi_ctl_rvalid <= 1'b1;
            s_axi_ctl_rresp  <= cpl_resp;
          end else begin
            s_axi_ctl_bvalid <= 1'b1;
            s_axi_ctl_bresp  <= cpl_resp;
          end
        end
      end
      if (resp_done) begin                      // Back to idle
        s_axi_ctl_bvalid    <= 1'b0;
        s_axi_ctl_rvalid    <= 1'b0;
        request_in_progress <= 1'b0;
        resp_issued         <= 1'b0;
        cpl_status          <= '0;
        msg_sent            <= 1'b0;
      end
    end
  end

  // Read data cleared on timeout
  always_ff @(posedge com_cclk) begin
    if (result_take && rd_req) begin
      s_axi_ctl_rdata <= timeout_hit ? 32'h0 : cpl_payload;
    end
  end

endmodule

`default_nettype wire

//--- cfg_tlp_tx.sv
// Takes one request at a time; sideband inputs are sampled as each beat is loaded
`default_nettype none
`include "cfg_consts.svh"

module cfg_tlp_tx (
  input  logic           com_cclk,
  input  logic           com_sysrst,
  input  logic           wr_accept,
  input  logic           rd_accept,
  input  logic [31:0]    s_axi_ctl_awaddr,
  input  logic [31:0]    s_axi_ctl_wdata,
  input  logic [3:0]     s_axi_ctl_wstrb,
  input  logic [31:0]    s_axi_ctl_araddr,
  input  logic           cfg_type,
  input  logic [15:0]    requester_id,
  input  logic           msg_req,
  input  logic [7:0]     slot_power_limit_value,
  input  logic [1:0]     slot_power_limit_scale,
  input  logic           cpl_match,
  output cfg_pkg::beat_t s_axis_cfg_tdata,
  output logic           s_axis_cfg_tvalid,
  output cfg_pkg::strb_t s_axis_cfg_tstrb,
  output logic           s_axis_cfg_tlast,
  input  logic           s_axis_cfg_tready,
  output logic           req_sent,
  output logic           msg_done,
  output cfg_pkg::tag_t  pending_tag,
  output logic           rd_pending
);

  import cfg_pkg::*;

  logic        is_msg;       // Power limit message in flight
  logic        is_rd;        // CfgRd in flight
  logic [1:0]  beat_cnt;     // Index of beat on the bus
  logic [31:0] addr_q;
  logic [31:0] wdata_q;
  tag_t        next_tag;     // Tag for the next Cfg request
  logic        hdr_msg;      // Message write being taken
  logic        cfg_start;    // Cfg request being taken
  logic        beat_fire;
  logic        last_fire;
  logic [2:0]  cfg_fmt;
  logic [3:0]  first_be;
  logic [31:0] addr_dw;      // Bus, device, function, register
  beat_t       hdr_beat;
  beat_t       next_beat;
  strb_t       next_strb;
  logic        next_last;

  assign hdr_msg   = wr_accept && msg_req;
  assign cfg_start = rd_accept || (wr_accept && !msg_req);
  assign beat_fire = s_axis_cfg_tvalid && s_axis_cfg_tready;
  assign last_fire = beat_fire && s_axis_cfg_tlast;
  assign req_sent  = last_fire && !is_msg;      // Starts the timer
  assign msg_done  = last_fire && is_msg;

  assign cfg_fmt   = wr_accept ? `CFG_FMT_WR : `CFG_FMT_RD;
  assign first_be  = wr_accept ? s_axi_ctl_wstrb : 4'hF;   // Reads fetch the whole DW
  assign addr_dw   = {addr_q[27:20], addr_q[19:15], addr_q[14:12], 4'b0000, addr_q[11:0]};

  // DW1 in the upper half, DW0 in the lower half
  always_comb begin
    if (hdr_msg) begin
      hdr_beat = {requester_id, 8'h00, `MSG_CODE_SPL,
                  `MSG_FMT, `MSG_TYPE, 14'b0, `TLP_LEN_ONE};
    end else begin
      hdr_beat = {requester_id, 5'b00000, next_tag, 4'b0000, first_be,
                  cfg_fmt, `CFG_TYPE_HI, cfg_type, 14'b0, `TLP_LEN_ONE};
    end
  end

  // Beat that follows the one on the bus
  always_comb begin
    next_last = 1'b1;
    if (!is_msg) begin
      next_beat = {(is_rd ? 32'h0 : wdata_q), addr_dw};
      next_strb = is_rd ? `STRB_LOW : `STRB_FULL;
    end else if (beat_cnt == 2'd0) begin
      next_beat = '0;                           // Message DW2/DW3 reserved
      next_strb = `STRB_FULL;
      next_last = 1'b0;
    end else begin
      next_beat = {32'h0, slot_power_limit_value, 6'b0, slot_power_limit_scale, 16'h0};
      next_strb = `STRB_LOW;
    end
  end

  always_ff @(posedge com_cclk) begin
    if (com_sysrst) begin
      s_axis_cfg_tvalid <= 1'b0;
      s_axis_cfg_tlast  <= 1'b0;
      s_axis_cfg_tstrb  <= '0;
      beat_cnt          <= 2'd0;
      is_msg            <= 1'b0;
      is_rd             <= 1'b0;
      next_tag          <= '0;
      pending_tag       <= '0;
      rd_pending        <= 1'b0;
    end else begin
      if (wr_accept || rd_accept) begin         // Header beat
        s_axis_cfg_tvalid <= 1'b1;
        s_axis_cfg_tlast  <= 1'b0;
        s_axis_cfg_tstrb  <= `STRB_FULL;
        beat_cnt          <= 2'd0;
        is_msg            <= hdr_msg;
        is_rd             <= rd_accept;
      end else if (last_fire) begin
        s_axis_cfg_tvalid <= 1'b0;
        s_axis_cfg_tlast  <= 1'b0;
        s_axis_cfg_tstrb  <= '0;
      end else if (beat_fire) begin             // Stalls hold the beat
        s_axis_cfg_tlast  <= next_last;
        s_axis_cfg_tstrb  <= next_strb;
        beat_cnt          <= beat_cnt + 2'd1;
      end
      if (cfg_start) begin                      // Messages keep the tag
        pending_tag <= next_tag;
        next_tag    <= next_tag + 3'd1;
      end
      if (rd_accept) begin
        rd_pending <= 1'b1;
      end else if (wr_accept || cpl_match) begin
        rd_pending <= 1'b0;
      end
    end
  end

  always_ff @(posedge com_cclk) begin
    if (wr_accept) begin
      addr_q  <= s_axi_ctl_awaddr;
      wdata_q <= s_axi_ctl_wdata;
    end else if (rd_accept) begin
      addr_q  <= s_axi_ctl_araddr;
    end
    if (wr_accept || rd_accept) begin
      s_axis_cfg_tdata <= hdr_beat;
    end else if (beat_fire && !s_axis_cfg_tlast) begin
      s_axis_cfg_tdata <= next_beat;
    end
  end

endmodule

`default_nettype wire

//--- cpl_rx.sv
// Two-beat completions only; the SOF beat holds the status and the last beat the tag
`default_nettype none
`include "cfg_consts.svh"

module cpl_rx (
  input  logic                   com_cclk,
  input  logic                   com_sysrst,
  input  cfg_pkg::beat_t         m_axis_cfg_tdata,
  input  logic                   m_axis_cfg_tvalid,
  output logic                   m_axis_cfg_tready,
  input  cfg_pkg::strb_t         m_axis_cfg_tstrb,
  input  logic                   m_axis_cfg_tlast,
  input  logic [`RX_TUSER_W-1:0] m_axis_cfg_tuser,
  input  cfg_pkg::tag_t          pending_tag,
  input  logic                   rd_pending,     // Payload kept for reads only
  output logic                   cpl_match,
  output cfg_pkg::cpl_status_t   cpl_status_q,
  output logic [31:0]            cpl_payload
);

  import cfg_pkg::*;

  logic beat_fire;
  logic last_fire;
  tag_t cpl_tag;     // Tag in the final beat

  assign beat_fire = m_axis_cfg_tvalid && m_axis_cfg_tready;
  assign last_fire = beat_fire && m_axis_cfg_tlast;
  assign cpl_tag   = m_axis_cfg_tdata[10:8];

  always_ff @(posedge com_cclk) begin
    if (com_sysrst) begin
      m_axis_cfg_tready <= 1'b0;
      cpl_match         <= 1'b0;
      cpl_status_q      <= '0;
    end else begin
      cpl_match <= 1'b0;
      if (m_axis_cfg_tvalid) begin
        m_axis_cfg_tready <= 1'b1;
      end
      if (last_fire) begin                    // Stale tags drained silently
        m_axis_cfg_tready <= 1'b0;
        cpl_match         <= (cpl_tag == pending_tag);
      end
      if (beat_fire && m_axis_cfg_tuser[`RX_SOF_BIT]) begin
        cpl_status_q <= m_axis_cfg_tdata[47:45];
      end
    end
  end

  always_ff @(posedge com_cclk) begin
    if (last_fire) begin
      if (!rd_pending) begin
        cpl_payload <= 32'h0;
      end else if (m_axis_cfg_tstrb == `STRB_FULL) begin
        cpl_payload <= m_axis_cfg_tdata[63:32];
      end else begin
        cpl_payload <= m_axis_cfg_tdata[31:0];
      end
    end
  end

endmodule

`default_nettype wire

//--- cpl_timer.sv
// Single fixed timeout; only Cfg requests start it and the b/r handshake clears it
`default_nettype none
`include "cfg_consts.svh"

module cpl_timer (
  input  logic com_cclk,
  input  logic com_sysrst,
  input  logic req_sent,
  input  logic resp_done,
  output logic timeout_hit,
  output logic cfg_timeout
);

  import cfg_pkg::*;

  logic [31:0] timer_value;   // Cycles since the request left
  logic        running;

  assign timeout_hit = running && (timer_value == `CPL_TIMEOUT_CYCLES);

  always_ff @(posedge com_cclk) begin
    if (com_sysrst) begin
      timer_value <= '0;
      running     <= 1'b0;
      cfg_timeout <= 1'b0;
    end else begin
      if (running) begin
        timer_value <= timer_value + 32'd1;
      end
      if (timeout_hit) begin            // Single pulse with the level held
        running     <= 1'b0;
        cfg_timeout <= 1'b1;
      end
      if (req_sent) begin
        running     <= 1'b1;
        timer_value <= 32'd1;
      end
      if (resp_done) begin
        running     <= 1'b0;
        timer_value <= '0;
        cfg_timeout <= 1'b0;
      end
    end
  end

endmodule

`default_nettype wire

//--- cfg_bridge_top.sv
// Root port only, 64-bit stream, single clock; one configuration request outstanding at a time
`default_nettype none
`include "cfg_consts.svh"

module cfg_bridge_top (
  input  logic                   com_cclk,
  input  logic                   com_sysrst,
  input  logic [31:0]            s_axi_ctl_awaddr,
  input  logic                   s_axi_ctl_awvalid,
  output logic                   s_axi_ctl_awready,
  input  logic [31:0]            s_axi_ctl_wdata,
  input  logic [3:0]             s_axi_ctl_wstrb,
  input  logic                   s_axi_ctl_wvalid,
  output logic                   s_axi_ctl_wready,
  output cfg_pkg::axi_resp_t     s_axi_ctl_bresp,
  output logic                   s_axi_ctl_bvalid,
  input  logic                   s_axi_ctl_bready,
  input  logic [31:0]            s_axi_ctl_araddr,
  input  logic                   s_axi_ctl_arvalid,
  output logic                   s_axi_ctl_arready,
  output logic [31:0]            s_axi_ctl_rdata,
  output cfg_pkg::axi_resp_t     s_axi_ctl_rresp,
  output logic                   s_axi_ctl_rvalid,
  input  logic                   s_axi_ctl_rready,
  output cfg_pkg::beat_t         s_axis_cfg_tdata,
  output logic                   s_axis_cfg_tvalid,
  input  logic                   s_axis_cfg_tready,
  output cfg_pkg::strb_t         s_axis_cfg_tstrb,
  output logic                   s_axis_cfg_tlast,
  input  cfg_pkg::beat_t         m_axis_cfg_tdata,
  input  logic                   m_axis_cfg_tvalid,
  output logic                   m_axis_cfg_tready,
  input  cfg_pkg::strb_t         m_axis_cfg_tstrb,
  input  logic                   m_axis_cfg_tlast,
  input  logic [`RX_TUSER_W-1:0] m_axis_cfg_tuser,
  input  logic                   cfg_type,
  input  logic [15:0]            requester_id,
  input  logic                   msg_req,
  input  logic [7:0]             slot_power_limit_value,
  input  logic [1:0]             slot_power_limit_scale,
  output logic                   msg_sent,
  output cfg_pkg::cpl_status_t   cpl_status,
  output logic                   cfg_timeout
);

  import cfg_pkg::*;

  logic        wr_accept;      // aw/w handshake
  logic        rd_accept;      // ar handshake
  logic        resp_done;      // b or r handshake
  logic        msg_done;       // Message last beat taken
  logic        req_sent;       // Cfg last beat taken
  tag_t        pending_tag;
  logic        rd_pending;
  logic        cpl_match;      // Also clears rd_pending in the tx side
  cpl_status_t cpl_status_q;
  logic [31:0] cpl_payload;
  logic        timeout_hit;

  // Port names match the nets above one to one
  axil_req_ctl u_axil_req_ctl (.*);
  cfg_tlp_tx   u_cfg_tlp_tx   (.*);
  cpl_rx       u_cpl_rx       (.*);
  cpl_timer    u_cpl_timer    (.*);

endmodule

`default_nettype wire

//--- tb_cfg_bridge.sv
// Self-checking bench for one completer that answers in order; the run is bounded by a cycle limit
`default_nettype none
`include "cfg_consts.svh"

module tb_cfg_bridge;

  timeunit 1ns;
  timeprecision 1ps;

  import cfg_pkg::*;

  localparam int cycle_limit = 5 * `CPL_TIMEOUT_CYCLES + 2000;
  localparam logic [`RX_TUSER_W-1:0] sof_user = `RX_TUSER_W'(1) << `RX_SOF_BIT;

  logic com_cclk = 1'b0;
  logic com_sysrst;
  logic [31:0] s_axi_ctl_awaddr, s_axi_ctl_wdata, s_axi_ctl_araddr, s_axi_ctl_rdata;
  logic [3:0]  s_axi_ctl_wstrb;
  logic s_axi_ctl_awvalid, s_axi_ctl_awready, s_axi_ctl_wvalid, s_axi_ctl_wready;
  logic s_axi_ctl_bvalid, s_axi_ctl_bready, s_axi_ctl_arvalid, s_axi_ctl_arready;
  logic s_axi_ctl_rvalid, s_axi_ctl_rready;
  axi_resp_t s_axi_ctl_bresp, s_axi_ctl_rresp;
  beat_t s_axis_cfg_tdata, m_axis_cfg_tdata;
  strb_t s_axis_cfg_tstrb, m_axis_cfg_tstrb;
  logic s_axis_cfg_tvalid, s_axis_cfg_tready, s_axis_cfg_tlast;
  logic m_axis_cfg_tvalid, m_axis_cfg_tready, m_axis_cfg_tlast;
  logic [`RX_TUSER_W-1:0] m_axis_cfg_tuser;
  logic        cfg_type, msg_req, msg_sent, cfg_timeout;
  logic [15:0] requester_id;
  logic [7:0]  slot_power_limit_value;
  logic [1:0]  slot_power_limit_scale;
  cpl_status_t cpl_status;

  integer      seed = 32'hac46;   // Fixed stimulus sequence
  int          cycle_cnt = 0;
  int          test_errs = 0;
  int          total_errs = 0;
  int          tests_run = 0;
  tag_t        exp_tag = '0;      // Next tag the bridge should use
  tag_t        sent_tag;          // Tag seen in the last header
  logic [31:0] req_addr, req_data;
  logic [3:0]  req_strb;
  beat_t       tx_data [3];       // Beats accepted from the tx stream
  strb_t       tx_strb [3];
  logic        tx_last [3];

  cfg_bridge_top uut (.*);

  always #20 com_cclk = ~com_cclk;   // 40 ns period

  always @(posedge com_cclk) begin
    cycle_cnt <= cycle_cnt + 1;
    if (cycle_cnt >= cycle_limit) begin
      $display("Run stopped after %0d cycles without finishing the tests", cycle_limit);
      $display("tests failed");
      $finish;
    end
  end

  task automatic check_val(input string name, input logic [63:0] expected,
                           input logic [63:0] actual);
    assert (actual === expected)
      else begin
        $display("Error at %0d ns: %s expected %h, got %h", $time, name, expected, actual);
        test_errs++;
      end
  endtask

  task automatic check_low(input string name, input logic value);
    check_val(name, 64'h0, 64'(value));
  endtask

  task automatic end_test(input string name);
    tests_run++;
    total_errs += test_errs;
    $display("Test %0d %s: %s", tests_run, name, (test_errs == 0) ? "ok" : "FAILED");
    test_errs = 0;
  endtask

  // PCIe 3DW Cfg header with DW1 in the upper half
  function automatic beat_t cfg_header(input logic [2:0] fmt, input tag_t tag,
                                       input logic [3:0] first_be);
    logic [31:0] dw0;
    logic [31:0] dw1;
    dw0 = {fmt, `CFG_TYPE_HI, cfg_type, 14'h0, `TLP_LEN_ONE};
    dw1 = {requester_id, 5'h0, tag, 4'h0, first_be};
    return {dw1, dw0};
  endfunction

  // Bus, device, function, register
  function automatic logic [31:0] addr_fields(input logic [31:0] a);
    return {a[27:20], a[19:15], a[14:12], 4'h0, a[11:0]};
  endfunction

  task automatic axi_request(input logic is_read, input logic [31:0] addr,
                             input logic [31:0] data, input logic [3:0] strb);
    @(posedge com_cclk);
    if (is_read) begin
      s_axi_ctl_araddr  <= addr;
      s_axi_ctl_arvalid <= 1'b1;
    end else begin
      s_axi_ctl_awaddr  <= addr;
      s_axi_ctl_wdata   <= data;
      s_axi_ctl_wstrb   <= strb;
      s_axi_ctl_awvalid <= 1'b1;
      s_axi_ctl_wvalid  <= 1'b1;
    end
    @(negedge com_cclk);
    while (!(is_read ? s_axi_ctl_arready : s_axi_ctl_awready)) @(negedge com_cclk);
    if (!is_read) check_val("s_axi_ctl_wready", 64'h1, 64'(s_axi_ctl_wready));
    @(posedge com_cclk);                        // Handshake on this edge
    s_axi_ctl_arvalid <= 1'b0;
    s_axi_ctl_awvalid <= 1'b0;
    s_axi_ctl_wvalid  <= 1'b0;
  endtask

  // Takes n beats under random tready stalls
  task automatic collect_tx(input int n_beats);
    int          idx;
    logic        holding;
    beat_t       held;
    logic [31:0] rnd;
    idx = 0;
    holding = 1'b0;
    held = '0;
    while (idx < n_beats) begin
      @(posedge com_cclk);
      rnd = $random(seed);
      s_axis_cfg_tready <= (rnd[1:0] != 2'b00);   // Roughly one stall in four
      @(negedge com_cclk);
      if (s_axis_cfg_tvalid) begin
        if (holding) begin
          check_val("s_axis_cfg_tdata under stall", held, s_axis_cfg_tdata);
        end
        if (s_axis_cfg_tready) begin
          tx_data[idx] = s_axis_cfg_tdata;
          tx_strb[idx] = s_axis_cfg_tstrb;
          tx_last[idx] = s_axis_cfg_tlast;
          idx++;
          holding = 1'b0;
        end else begin
          held = s_axis_cfg_tdata;
          holding = 1'b1;
        end
      end
    end
    @(posedge com_cclk);
    s_axis_cfg_tready <= 1'b0;
    @(negedge com_cclk);
    check_low("s_axis_cfg_tvalid after last beat", s_axis_cfg_tvalid);
  endtask

  // Random CfgRd or CfgWr with checks of both beats and the tag
  task automatic issue_cfg(input logic is_read);
    logic [31:0] rnd;
    rnd = $random(seed);
    req_addr = rnd;
    rnd = $random(seed);
    req_data = rnd;
    rnd = $random(seed);
    req_strb = rnd[3:0];
    @(posedge com_cclk);
    cfg_type <= rnd[4];                         // Both Cfg types over the run
    axi_request(is_read, req_addr, req_data, req_strb);
    collect_tx(2);
    if (is_read) begin
      check_val("tx beat 0", cfg_header(`CFG_FMT_RD, exp_tag, 4'hF), tx_data[0]);
      check_val("tx beat 1", {32'h0, addr_fields(req_addr)}, tx_data[1]);
      check_val("tx beat 1 tstrb", 64'(`STRB_LOW), 64'(tx_strb[1]));
    end else begin
      check_val("tx beat 0", cfg_header(`CFG_FMT_WR, exp_tag, req_strb), tx_data[0]);
      check_val("tx beat 1", {req_data, addr_fields(req_addr)}, tx_data[1]);
      check_val("tx beat 1 tstrb", 64'(`STRB_FULL), 64'(tx_strb[1]));
    end
    check_val("tx beat 0 tstrb", 64'(`STRB_FULL), 64'(tx_strb[0]));
    check_val("tx beat 0 tlast", 64'h0, 64'(tx_last[0]));
    check_val("tx beat 1 tlast", 64'h1, 64'(tx_last[1]));
    check_val("tag", 64'(exp_tag), 64'(tx_data[0][42:40]));   // DW1 bits 10:8
    sent_tag = tx_data[0][42:40];
    exp_tag = exp_tag + 3'd1;
  endtask

  // Two-beat completer model
  task automatic send_cpl(input tag_t tag, input cpl_status_t status,
                          input logic [31:0] payload);
    @(posedge com_cclk);
    m_axis_cfg_tdata  <= {16'h0, status, 45'h0};   // Status in 47:45
    m_axis_cfg_tuser  <= sof_user;
    m_axis_cfg_tstrb  <= `STRB_FULL;
    m_axis_cfg_tlast  <= 1'b0;
    m_axis_cfg_tvalid <= 1'b1;
    @(negedge com_cclk);
    while (!m_axis_cfg_tready) @(negedge com_cclk);
    @(posedge com_cclk);
    m_axis_cfg_tdata  <= {payload, 21'h0, tag, 8'h0};   // Tag in 10:8
    m_axis_cfg_tuser  <= '0;
    m_axis_cfg_tlast  <= 1'b1;
    @(negedge com_cclk);
    while (!m_axis_cfg_tready) @(negedge com_cclk);
    @(posedge com_cclk);
    m_axis_cfg_tvalid <= 1'b0;
    m_axis_cfg_tlast  <= 1'b0;
  endtask

  task automatic take_resp(input logic is_read, input axi_resp_t exp_resp,
                           input logic [31:0] exp_data, input cpl_status_t exp_status,
                           input logic exp_timeout, input logic exp_msg);
    @(negedge com_cclk);
    while (!(is_read ? s_axi_ctl_rvalid : s_axi_ctl_bvalid)) @(negedge com_cclk);
    if (is_read) begin
      check_val("s_axi_ctl_rresp", 64'(exp_resp), 64'(s_axi_ctl_rresp));
      if (exp_resp == resp_okay || exp_timeout) begin   // Data defined here only
        check_val("s_axi_ctl_rdata", 64'(exp_data), 64'(s_axi_ctl_rdata));
      end
    end else begin
      check_val("s_axi_ctl_bresp", 64'(exp_resp), 64'(s_axi_ctl_bresp));
    end
    check_val("cpl_status", 64'(exp_status), 64'(cpl_status));
    check_val("cfg_timeout", 64'(exp_timeout), 64'(cfg_timeout));
    check_val("msg_sent", 64'(exp_msg), 64'(msg_sent));
    @(posedge com_cclk);
    s_axi_ctl_rready <= is_read;
    s_axi_ctl_bready <= !is_read;
    @(posedge com_cclk);                        // Handshake on this edge
    s_axi_ctl_rready <= 1'b0;
    s_axi_ctl_bready <= 1'b0;
    @(negedge com_cclk);
    check_low("s_axi_ctl_rvalid after handshake", s_axi_ctl_rvalid);
    check_low("s_axi_ctl_bvalid after handshake", s_axi_ctl_bvalid);
    check_low("cfg_timeout after handshake", cfg_timeout);
    check_low("msg_sent after handshake", msg_sent);
  endtask

  initial begin : stimulus
    logic [31:0] rnd;
    cpl_status_t status;
    rnd = $random(seed);
    com_sysrst             <= 1'b1;
    s_axi_ctl_awaddr       <= '0;
    s_axi_ctl_awvalid      <= 1'b0;
    s_axi_ctl_wdata        <= '0;
    s_axi_ctl_wstrb        <= '0;
    s_axi_ctl_wvalid       <= 1'b0;
    s_axi_ctl_bready       <= 1'b0;
    s_axi_ctl_araddr       <= '0;
    s_axi_ctl_arvalid      <= 1'b0;
    s_axi_ctl_rready       <= 1'b0;
    s_axis_cfg_tready      <= 1'b0;
    m_axis_cfg_tdata       <= '0;
    m_axis_cfg_tvalid      <= 1'b0;
    m_axis_cfg_tstrb       <= '0;
    m_axis_cfg_tlast       <= 1'b0;
    m_axis_cfg_tuser       <= '0;
    cfg_type               <= rnd[0];
    requester_id           <= rnd[31:16];
    msg_req                <= 1'b0;
    slot_power_limit_value <= '0;
    slot_power_limit_scale <= '0;
    repeat (8) @(posedge com_cclk);
    com_sysrst <= 1'b0;
    @(negedge com_cclk);
    check_low("s_axi_ctl_awready", s_axi_ctl_awready);
    check_low("s_axi_ctl_wready", s_axi_ctl_wready);
    check_low("s_axi_ctl_arready", s_axi_ctl_arready);
    check_low("s_axi_ctl_bvalid", s_axi_ctl_bvalid);
    check_low("s_axi_ctl_rvalid", s_axi_ctl_rvalid);
    check_low("s_axis_cfg_tvalid", s_axis_cfg_tvalid);
    check_low("m_axis_cfg_tready", m_axis_cfg_tready);
    check_low("msg_sent", msg_sent);
    check_low("cfg_timeout", cfg_timeout);
    end_test("reset state");

    repeat (2) begin
      issue_cfg(1'b0);
      send_cpl(sent_tag, 3'd0, 32'h0);
      take_resp(1'b0, resp_okay, 32'h0, 3'd0, 1'b0, 1'b0);
    end
    end_test("cfg write format");

    issue_cfg(1'b1);
    rnd = $random(seed);
    send_cpl(sent_tag, 3'd0, rnd);
    take_resp(1'b1, resp_okay, rnd, 3'd0, 1'b0, 1'b0);
    issue_cfg(1'b1);
    rnd = $random(seed);
    status = rnd[2:0] | 3'b001;                 // Any nonzero status
    send_cpl(sent_tag, status, rnd);
    take_resp(1'b1, resp_slverr, rnd, status, 1'b0, 1'b0);
    end_test("read response");

    issue_cfg(1'b1);
    send_cpl(sent_tag + 3'd3, 3'd0, 32'hdead_beef);   // Wrong tag
    repeat (10) begin
      @(negedge com_cclk);
      check_low("s_axi_ctl_rvalid on stale completion", s_axi_ctl_rvalid);
    end
    rnd = $random(seed);
    send_cpl(sent_tag, 3'd0, rnd);
    take_resp(1'b1, resp_okay, rnd, 3'd0, 1'b0, 1'b0);
    end_test("stale completion");

    for (int i = 0; i < 9; i++) begin           // Crosses the tag wrap
      issue_cfg(i[0]);
      rnd = $random(seed);
      send_cpl(sent_tag, 3'd0, rnd);
      take_resp(i[0], resp_okay, rnd, 3'd0, 1'b0, 1'b0);
    end
    end_test("tag sequence");

    @(posedge com_cclk);
    rnd = $random(seed);
    msg_req                <= 1'b1;
    slot_power_limit_value <= rnd[7:0];
    slot_power_limit_scale <= rnd[9:8];
    rnd = $random(seed);
    axi_request(1'b0, rnd, rnd, 4'hF);
    collect_tx(3);
    check_val("msg beat 0", {requester_id, 8'h00, `MSG_CODE_SPL, `MSG_FMT, `MSG_TYPE,
                             14'h0, `TLP_LEN_ONE}, tx_data[0]);
    check_val("msg beat 1", 64'h0, tx_data[1]);
    check_val("msg beat 2", {32'h0, slot_power_limit_value, 6'h0, slot_power_limit_scale,
                             16'h0}, tx_data[2]);
    check_val("msg beat 1 tstrb", 64'(`STRB_FULL), 64'(tx_strb[1]));
    check_val("msg beat 2 tstrb", 64'(`STRB_LOW), 64'(tx_strb[2]));
    check_val("msg tlast pattern", 64'b001, 64'({tx_last[0], tx_last[1], tx_last[2]}));
    take_resp(1'b0, resp_okay, 32'h0, 3'd0, 1'b0, 1'b1);
    @(posedge com_cclk);
    msg_req <= 1'b0;
    issue_cfg(1'b1);                            // Tag must not have moved
    rnd = $random(seed) | 32'h1;                // Nonzero read data before the timeout
    send_cpl(sent_tag, 3'd0, rnd);
    take_resp(1'b1, resp_okay, rnd, 3'd0, 1'b0, 1'b0);
    end_test("slot power limit message");

    issue_cfg(1'b1);                            // Completer stays silent
    take_resp(1'b1, resp_slverr, 32'h0, 3'd0, 1'b1, 1'b0);
    end_test("completion timeout");

    $display("%0d tests run, %0d checks failed", tests_run, total_errs);
    if (total_errs == 0) begin
      $display("all tests passed");
    end else begin
      $display("tests failed");
    end
    $finish;
  end

endmodule

`default_nettype wire

//--- project.f
+incdir+.
cfg_pkg.sv
axil_req_ctl.sv
cfg_tlp_tx.sv
cpl_rx.sv
cpl_timer.sv
cfg_bridge_top.sv
tb_cfg_bridge.sv

//--- run.sh
#!/bin/sh
# Build and run the testbench with Verilator
set -e
cd "$(dirname "$0")"
verilator --binary --timing --assert -f project.f --top-module tb_cfg_bridge
out=$(./obj_dir/Vtb_cfg_bridge)
echo "$out"
if echo "$out" | grep -qx "all tests passed"; then
  exit 0
else
  exit 1
fi
